//--- filelist.f
verilog/decode_pkg.sv
verilog/imm_gen.sv
verilog/inst_decoder.sv
verilog/skid_buffer.sv
verilog/dual_decode.sv
verification/dual_decode_assertions.sv
verification/dual_decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the log
verilator --binary --timing --assert -f filelist.f --top-module dual_decode_tb \
    -o sim_dual_decode > build.log 2>&1 \
    && ./obj_dir/sim_dual_decode > sim.log 2>&1 \
    || { echo "build or simulation aborted"; exit 1; }
grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All checks passed" sim.log || { echo "simulation FAILED"; exit 1; }
echo "simulation passed"

//--- verification/dual_decode_tb.sv
`timescale 1ns/1ps

module dual_decode_tb
    import decode_pkg::*;
();
    localparam int N_ENTRIES = 34;
    localparam int N_PAIRS   = N_ENTRIES / 2;
    localparam int RST_CYC   = 16;
    // major opcodes with the low 11 bits
    localparam logic [6:0] OPC_IMM   = 7'h13;
    localparam logic [6:0] OPC_IMM32 = 7'h1b;
    localparam logic [6:0] OPC_OP    = 7'h33;
    localparam logic [6:0] OPC_OP32  = 7'h3b;
    localparam logic [6:0] OPC_LUI   = 7'h37;
    localparam logic [6:0] OPC_AUIPC = 7'h17;

    typedef struct packed {
        logic [31:0]  inst;
        logic         legal;
        pipe_e        pipe;
        logic         op2_sel;
        xarith_ctrl_t xa;
        xlogic_ctrl_t xl;
        logic [31:0]  imm;
    } entry_t;

    logic          i_clk;
    logic          i_rst_n;
    logic          i_input_valid;
    logic          o_input_ready;
    logic [31:0]   i_inst0;
    logic [31:0]   i_inst1;
    logic          i_output_ready;
    logic          o_output_valid;
    decoded_t      o_bundle0;
    decoded_t      o_bundle1;

    entry_t        tbl [N_ENTRIES];
    int            n_tbl;
    decoded_pair_t sent_q [$];
    logic [31:0]   lcg_state;
    int            err_count;

    dual_decode DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // watchdog, 40 cycles per table entry on top of reset
    initial begin
        #((RST_CYC + N_ENTRIES * 40) * 20);
        $display("run exceeded its time budget, DUT stopped handshaking");
        $display("Checks failed");
        $fatal(1);
    end

    function automatic logic lcg_bit();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[16];
    endfunction

    function automatic logic [31:0] itype(logic [11:0] imm, logic [2:0] f3, logic [6:0] op);
        return {imm, 5'd2, f3, 5'd1, op};
    endfunction

    function automatic logic [31:0] rtype(logic [6:0] f7, logic [2:0] f3, logic [6:0] op);
        return {f7, 5'd7, 5'd6, f3, 5'd5, op};
    endfunction

    function automatic xarith_ctrl_t arith_ctrl(xarith_op_e op, logic sub, logic uns, logic word);
        xarith_ctrl_t c;
        c             = '0;
        c.op          = op;
        c.sub         = sub;
        c.is_unsigned = uns;
        c.word        = word;
        return c;
    endfunction

    function automatic xlogic_ctrl_t logic_ctrl(xlogic_op_e op, logic word);
        xlogic_ctrl_t c;
        c      = '0;
        c.op   = op;
        c.word = word;
        return c;
    endfunction

    task automatic add_entry(logic [31:0] inst, logic legal, pipe_e pipe, logic op2,
                             xarith_ctrl_t xa, xlogic_ctrl_t xl, logic [31:0] imm);
        tbl[n_tbl] = '{inst, legal, pipe, op2, xa, xl, imm};
        n_tbl      = n_tbl + 1;
    endtask

    // register fields come straight from the fixed instruction fields
    function automatic decoded_t expected(entry_t e);
        decoded_t d;
        d         = '0;
        d.legal   = e.legal;
        d.rs1     = e.inst[19:15];
        d.rs2     = e.inst[24:20];
        d.rd      = e.inst[11:7];
        d.imm     = e.imm;
        d.pipe    = e.pipe;
        d.op2_sel = e.op2_sel;
        d.xarith  = e.xa;
        d.xlogic  = e.xl;
        return d;
    endfunction

    task automatic fail_run(string msg);
        err_count = err_count + 1;
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_decoded(string name, decoded_t exp, decoded_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic fill_table();
        xarith_ctrl_t z_a;
        xlogic_ctrl_t z_l;
        z_a   = '0;
        z_l   = '0;
        n_tbl = 0;
        // op-imm group
        add_entry(itype(12'hffb, 3'd0, OPC_IMM), 1, PIPE_XARITH, 1, z_a, z_l, 32'hfffffffb);
        add_entry(itype(12'h064, 3'd2, OPC_IMM), 1, PIPE_XARITH, 1,
                  arith_ctrl(XARITH_SLT, 0, 0, 0), z_l, 32'h64);
        add_entry(itype(12'h7ff, 3'd3, OPC_IMM), 1, PIPE_XARITH, 1,
                  arith_ctrl(XARITH_SLT, 0, 1, 0), z_l, 32'h7ff);
        add_entry(itype(12'hfff, 3'd4, OPC_IMM), 1, PIPE_XLOGIC, 1, z_a,
                  logic_ctrl(XLOGIC_XOR, 0), 32'hffffffff);
        add_entry(itype(12'h123, 3'd6, OPC_IMM), 1, PIPE_XLOGIC, 1, z_a,
                  logic_ctrl(XLOGIC_OR, 0), 32'h123);
        add_entry(itype(12'h800, 3'd7, OPC_IMM), 1, PIPE_XLOGIC, 1, z_a,
                  logic_ctrl(XLOGIC_AND, 0), 32'hfffff800);
        add_entry(itype(12'h03f, 3'd1, OPC_IMM), 1, PIPE_XLOGIC, 1, z_a,
                  logic_ctrl(XLOGIC_SHF, 0), 32'h3f);
        add_entry(itype(12'h421, 3'd5, OPC_IMM), 1, PIPE_XLOGIC, 1, z_a,
                  logic_ctrl(XLOGIC_SHF, 0), 32'h421);
        // bad shift upper fields
        add_entry(itype(12'h205, 3'd5, OPC_IMM), 0, PIPE_XLOGIC, 1, z_a,
                  logic_ctrl(XLOGIC_SHF, 0), 32'h205);
        add_entry(itype(12'h401, 3'd1, OPC_IMM), 0, PIPE_XLOGIC, 1, z_a,
                  logic_ctrl(XLOGIC_SHF, 0), 32'h401);
        // op group, funct7 lands in imm[10:5]
        add_entry(rtype(7'h00, 3'd0, OPC_OP), 1, PIPE_XARITH, 0, z_a, z_l, 32'h0);
        add_entry(rtype(7'h20, 3'd0, OPC_OP), 1, PIPE_XARITH, 0,
                  arith_ctrl(XARITH_ADD, 1, 0, 0), z_l, 32'h400);
        add_entry(rtype(7'h00, 3'd3, OPC_OP), 1, PIPE_XARITH, 0,
                  arith_ctrl(XARITH_SLT, 0, 1, 0), z_l, 32'h0);
        add_entry(rtype(7'h20, 3'd5, OPC_OP), 1, PIPE_XLOGIC, 0, z_a,
                  logic_ctrl(XLOGIC_SHF, 0), 32'h400);
        add_entry(rtype(7'h20, 3'd1, OPC_OP), 0, PIPE_XLOGIC, 0, z_a,
                  logic_ctrl(XLOGIC_SHF, 0), 32'h400);
        add_entry(rtype(7'h01, 3'd7, OPC_OP), 0, PIPE_XLOGIC, 0, z_a,
                  logic_ctrl(XLOGIC_AND, 0), 32'h20);
        add_entry(rtype(7'h00, 3'd4, OPC_OP), 1, PIPE_XLOGIC, 0, z_a,
                  logic_ctrl(XLOGIC_XOR, 0), 32'h0);
        add_entry(rtype(7'h00, 3'd6, OPC_OP), 1, PIPE_XLOGIC, 0, z_a,
                  logic_ctrl(XLOGIC_OR, 0), 32'h0);
        // word groups
        add_entry(itype(12'hfff, 3'd0, OPC_IMM32), 1, PIPE_XARITH, 1,
                  arith_ctrl(XARITH_ADD, 0, 0, 1), logic_ctrl(XLOGIC_AND, 1), 32'hffffffff);
        add_entry(itype(12'h005, 3'd1, OPC_IMM32), 1, PIPE_XLOGIC, 1,
                  arith_ctrl(XARITH_ADD, 0, 0, 1), logic_ctrl(XLOGIC_SHF, 1), 32'h5);
        add_entry(itype(12'h41f, 3'd5, OPC_IMM32), 1, PIPE_XLOGIC, 1,
                  arith_ctrl(XARITH_ADD, 0, 0, 1), logic_ctrl(XLOGIC_SHF, 1), 32'h41f);
        add_entry(itype(12'h010, 3'd2, OPC_IMM32), 0, PIPE_NONE, 1,
                  arith_ctrl(XARITH_ADD, 0, 0, 1), logic_ctrl(XLOGIC_AND, 1), 32'h10);
        add_entry(rtype(7'h00, 3'd0, OPC_OP32), 1, PIPE_XARITH, 0,
                  arith_ctrl(XARITH_ADD, 0, 0, 1), logic_ctrl(XLOGIC_AND, 1), 32'h0);
        add_entry(rtype(7'h20, 3'd0, OPC_OP32), 1, PIPE_XARITH, 0,
                  arith_ctrl(XARITH_ADD, 1, 0, 1), logic_ctrl(XLOGIC_AND, 1), 32'h400);
        add_entry(rtype(7'h00, 3'd5, OPC_OP32), 1, PIPE_XLOGIC, 0,
                  arith_ctrl(XARITH_ADD, 0, 0, 1), logic_ctrl(XLOGIC_SHF, 1), 32'h0);
        add_entry(rtype(7'h20, 3'd1, OPC_OP32), 0, PIPE_XLOGIC, 0,
                  arith_ctrl(XARITH_ADD, 0, 0, 1), logic_ctrl(XLOGIC_SHF, 1), 32'h400);
        add_entry(rtype(7'h00, 3'd4, OPC_OP32), 0, PIPE_NONE, 0,
                  arith_ctrl(XARITH_ADD, 0, 0, 1), logic_ctrl(XLOGIC_AND, 1), 32'h0);
        // u format
        add_entry({20'h80001, 5'd3, OPC_LUI}, 1, PIPE_XARITH, 1, z_a, z_l, 32'h80001000);
        add_entry({20'h12345, 5'd4, OPC_AUIPC}, 1, PIPE_XARITH, 1, z_a, z_l, 32'h12345000);
        // sw -4, beq -8, jal 0x800, ld 0x7f0, custom-0
        add_entry({7'h7f, 5'd9, 5'd8, 3'd2, 5'h1c, 7'h23}, 0, PIPE_NONE, 0, z_a, z_l,
                  32'hfffffffc);
        add_entry({1'b1, 6'h3f, 5'd9, 5'd8, 3'd0, 4'hc, 1'b1, 7'h63}, 0, PIPE_NONE, 0,
                  z_a, z_l, 32'hfffffff8);
        add_entry({1'b0, 10'h000, 1'b1, 8'h00, 5'd1, 7'h6f}, 0, PIPE_NONE, 0, z_a, z_l,
                  32'h800);
        add_entry(itype(12'h7f0, 3'd3, 7'h03), 0, PIPE_NONE, 0, z_a, z_l, 32'h7f0);
        add_entry(32'h0000150b, 0, PIPE_NONE, 0, z_a, z_l, 32'h0);
    endtask

    // sends every pair, random_mode adds valid gaps and ready stalls
    task automatic run_table(bit random_mode);
        int            sent;
        int            recv;
        logic          pend;
        logic          stall_prev;
        decoded_t      hold0;
        decoded_t      hold1;
        decoded_pair_t exp_pair;
        decoded_pair_t got;
        sent       = 0;
        recv       = 0;
        pend       = 1'b0;
        stall_prev = 1'b0;
        while (recv < N_PAIRS) begin
            @(posedge i_clk);
            #2;
            if (sent < N_PAIRS) begin
                i_inst0       = tbl[2*sent].inst;
                i_inst1       = tbl[2*sent+1].inst;
                // once raised, valid holds until accepted
                i_input_valid = pend | !random_mode | lcg_bit();
            end else begin
                i_input_valid = 1'b0;
            end
            i_output_ready = !random_mode | lcg_bit();
            @(negedge i_clk);
            if (stall_prev) begin
                check_bit("stall valid", 1'b1, o_output_valid);
                check_decoded("stall lane0", hold0, o_bundle0);
                check_decoded("stall lane1", hold1, o_bundle1);
            end
            if (!random_mode) begin
                check_bit("input ready steady", 1'b1, o_input_ready);
                // a pair accepted on the last edge must be showing now
                check_bit("one cycle latency", sent_q.size() == 1, o_output_valid);
            end
            if (o_output_valid && i_output_ready) begin
                if (sent_q.size() == 0) begin
                    fail_run("output transfer with no pair outstanding");
                end
                exp_pair = sent_q.pop_front();
                check_decoded($sformatf("entry %0d", 2 * recv), exp_pair.lane0, o_bundle0);
                check_decoded($sformatf("entry %0d", 2 * recv + 1), exp_pair.lane1, o_bundle1);
                recv = recv + 1;
            end
            if (i_input_valid && o_input_ready) begin
                got.lane0 = expected(tbl[2*sent]);
                got.lane1 = expected(tbl[2*sent+1]);
                sent_q.push_back(got);
                sent = sent + 1;
                pend = 1'b0;
            end else begin
                pend = i_input_valid;
            end
            stall_prev = o_output_valid & ~i_output_ready;
            hold0      = o_bundle0;
            hold1      = o_bundle1;
        end
    endtask

    initial begin
        i_rst_n        = 1'b1;
        i_input_valid  = 1'b0;
        i_inst0        = '0;
        i_inst1        = '0;
        i_output_ready = 1'b0;
        lcg_state      = 32'h71ea3c3d;
        err_count      = 0;
        fill_table();
        repeat (RST_CYC) @(posedge i_clk);
        #2;
        i_rst_n = 1'b0;
        @(negedge i_clk);
        check_bit("valid after reset", 1'b0, o_output_valid);
        check_bit("ready after reset", 1'b1, o_input_ready);
        // full rate first, then random back-pressure
        run_table(1'b0);
        run_table(1'b1);
        @(posedge i_clk);
        #2;
        i_input_valid = 1'b0;
        @(negedge i_clk);
        // every pair has been taken, nothing may follow
        check_bit("no extra output", 1'b0, o_output_valid);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verification/dual_decode_assertions.sv
`timescale 1ns/1ps

module dual_decode_assertions
    import decode_pkg::*;
(
    input logic     i_clk,
    input logic     i_rst_n,
    input logic     i_output_ready,
    input logic     o_output_valid,
    input logic     o_input_ready,
    input logic     i_skid_full,
    input decoded_t o_bundle0,
    input decoded_t o_bundle1
);

    // stalled output must not move
    a_stall_stable: assert property (@(posedge i_clk) disable iff (i_rst_n)
        (o_output_valid && !i_output_ready) |=>
            (o_output_valid && $stable(o_bundle0) && $stable(o_bundle1)))
        else $error("output changed during a stall");

    // reset clears the output stage
    a_reset_clears: assert property (@(posedge i_clk)
        i_rst_n |=> !o_output_valid)
        else $error("output valid right after reset");

    // skid entry empties once the output drains, so fetch may send again
    a_ready_after_drain: assert property (@(posedge i_clk) disable iff (i_rst_n)
        !(o_output_valid && !i_output_ready) |=> (!i_skid_full && o_input_ready))
        else $error("skid entry still held after an unstalled cycle");

endmodule

bind dual_decode dual_decode_assertions u_sva (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_output_ready (i_output_ready),
    .o_output_valid (o_output_valid),
    .o_input_ready  (o_input_ready),
    .i_skid_full    (u_skid.skid_full),
    .o_bundle0      (o_bundle0),
    .o_bundle1      (o_bundle1)
);

//--- verilog/dual_decode.sv
`timescale 1ns/1ps

module dual_decode
    import decode_pkg::*;
(
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_input_valid,
    output logic              o_input_ready,
    input  logic [INST_W-1:0] i_inst0,
    input  logic [INST_W-1:0] i_inst1,
    input  logic              i_output_ready,
    output logic              o_output_valid,
    output decoded_t          o_bundle0,
    output decoded_t          o_bundle1
);
    // skid carries the whole pair as one flat word
    localparam int DATA_W = $bits(decoded_pair_t);

    decoded_t          dec0;
    decoded_t          dec1;
    decoded_pair_t     pair_in;
    decoded_pair_t     pair_out;
    logic [DATA_W-1:0] skid_out;

    // lane 0 is the older instruction
    inst_decoder u_dec0 (
        .i_inst (i_inst0),
        .o_dec  (dec0)
    );

    inst_decoder u_dec1 (
        .i_inst (i_inst1),
        .o_dec  (dec1)
    );

    assign pair_in.lane0 = dec0;
    assign pair_in.lane1 = dec1;

    // holds the decoded pair while issue stalls
    skid_buffer #(
        .DATA_W (DATA_W)
    ) u_skid (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_input_valid),
        .o_ready (o_input_ready),
        .i_data  (pair_in),
        .o_valid (o_output_valid),
        .i_ready (i_output_ready),
        .o_data  (skid_out)
    );

    assign pair_out  = skid_out;
    assign o_bundle0 = pair_out.lane0;
    assign o_bundle1 = pair_out.lane1;

endmodule

//--- verilog/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
    parameter int DATA_W = 32
) (
    input  logic              i_clk,
    input  logic              i_rst_n,
    input  logic              i_valid,
    output logic              o_ready,
    input  logic [DATA_W-1:0] i_data,
    output logic              o_valid,
    input  logic              i_ready,
    output logic [DATA_W-1:0] o_data
);
    // output stage
    logic [DATA_W-1:0] out_data;
    logic              out_valid;
    // skid stage
    logic [DATA_W-1:0] skid_data;
    logic              skid_full;
    logic              in_xfer;
    logic              out_open;

    // ready is just the registered skid occupancy
    assign o_ready  = ~skid_full;
    assign in_xfer  = i_valid & o_ready;
    // output reg can take new data when empty or draining
    assign out_open = ~out_valid | i_ready;

    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            out_valid <= 1'b0;
            skid_full <= 1'b0;
        end else if (out_open) begin
            // skid entry has priority, it is older
            out_valid <= skid_full | in_xfer;
            skid_full <= 1'b0;
        end else if (in_xfer) begin
            // stalled, park the pair
            skid_full <= 1'b1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (out_open) begin
            if (skid_full) begin
                out_data <= skid_data;
            end else if (in_xfer) begin
                out_data <= i_data;
            end
        end else if (in_xfer) begin
            skid_data <= i_data;
        end
    end

    assign o_valid = out_valid;
    assign o_data  = out_data;

endmodule

//--- verilog/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder
    import decode_pkg::*;
(
    input  logic [INST_W-1:0] i_inst,
    output decoded_t          o_dec
);
    major_op_e   opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm;
    // funct7 / shift upper field matches
    logic        f7_zero;
    logic        f7_alt;
    logic        f6_zero;
    logic        f6_alt;

    assign opcode  = major_op_e'(i_inst[6:2]);
    assign funct3  = i_inst[14:12];
    assign funct7  = i_inst[31:25];
    assign f7_zero = funct7 == 7'b0000000;
    assign f7_alt  = funct7 == 7'b0100000;
    // rv64 immediate shifts use a 6-bit shamt, so only 6 upper bits
    assign f6_zero = i_inst[31:26] == 6'b000000;
    assign f6_alt  = i_inst[31:26] == 6'b010000;

    imm_gen u_imm (
        .i_inst (i_inst),
        .o_imm  (imm)
    );

    always_comb begin
        // controls default to zero
        o_dec     = '0;
        o_dec.rs1 = i_inst[19:15];
        o_dec.rs2 = i_inst[24:20];
        o_dec.rd  = i_inst[11:7];
        o_dec.imm = imm;

        case (opcode)
            // addi slti sltiu xori ori andi slli srli srai
            OP_IMM: begin
                o_dec.op2_sel = 1'b1;
                case (funct3)
                    3'b000: begin
                        o_dec.legal     = 1'b1;
                        o_dec.pipe      = PIPE_XARITH;
                        o_dec.xarith.op = XARITH_ADD;
                    end
                    3'b001: begin
                        o_dec.legal     = f6_zero;
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_SHF;
                    end
                    3'b010, 3'b011: begin
                        o_dec.legal              = 1'b1;
                        o_dec.pipe               = PIPE_XARITH;
                        o_dec.xarith.op          = XARITH_SLT;
                        o_dec.xarith.is_unsigned = funct3[0];
                    end
                    3'b100: begin
                        o_dec.legal     = 1'b1;
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_XOR;
                    end
                    3'b101: begin
                        // srli or srai
                        o_dec.legal     = f6_zero | f6_alt;
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_SHF;
                    end
                    3'b110: begin
                        o_dec.legal     = 1'b1;
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_OR;
                    end
                    default: begin
                        // andi
                        o_dec.legal     = 1'b1;
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_AND;
                    end
                endcase
            end
            // add sub sll slt sltu xor srl sra or and
            OP: begin
                case (funct3)
                    3'b000: begin
                        o_dec.legal      = f7_zero | f7_alt;
                        o_dec.pipe       = PIPE_XARITH;
                        o_dec.xarith.op  = XARITH_ADD;
                        o_dec.xarith.sub = funct7[5];
                    end
                    3'b010, 3'b011: begin
                        o_dec.legal              = f7_zero;
                        o_dec.pipe               = PIPE_XARITH;
                        o_dec.xarith.op          = XARITH_SLT;
                        o_dec.xarith.is_unsigned = funct3[0];
                    end
                    3'b001, 3'b101: begin
                        // only the right shift has an arithmetic variant
                        o_dec.legal     = f7_zero | (f7_alt & funct3[2]);
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_SHF;
                    end
                    3'b100: begin
                        o_dec.legal     = f7_zero;
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_XOR;
                    end
                    3'b110: begin
                        o_dec.legal     = f7_zero;
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_OR;
                    end
                    default: begin
                        o_dec.legal     = f7_zero;
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_AND;
                    end
                endcase
            end
            // addiw slliw srliw sraiw, plus addw subw sllw srlw sraw
            OP_IMM_32, OP_32: begin
                o_dec.op2_sel     = opcode == OP_IMM_32;
                o_dec.xarith.word = 1'b1;
                o_dec.xlogic.word = 1'b1;
                case (funct3)
                    3'b000: begin
                        // addiw has no funct7, addw/subw do
                        o_dec.legal      = (opcode == OP_IMM_32) | f7_zero | f7_alt;
                        o_dec.pipe       = PIPE_XARITH;
                        o_dec.xarith.op  = XARITH_ADD;
                        o_dec.xarith.sub = (opcode == OP_32) & funct7[5];
                    end
                    3'b001, 3'b101: begin
                        o_dec.legal     = f7_zero | (f7_alt & funct3[2]);
                        o_dec.pipe      = PIPE_XLOGIC;
                        o_dec.xlogic.op = XLOGIC_SHF;
                    end
                    // no other word ops in rv64i
                    default: o_dec.legal = 1'b0;
                endcase
            end
            // lui adds to x0 inside the arith unit, auipc to the pc
            LUI, AUIPC: begin
                o_dec.legal     = 1'b1;
                o_dec.pipe      = PIPE_XARITH;
                o_dec.op2_sel   = 1'b1;
                o_dec.xarith.op = XARITH_ADD;
            end
            // everything else stays illegal
            default: ;
        endcase
    end

endmodule

//--- verilog/imm_gen.sv
`timescale 1ns/1ps

module imm_gen
    import decode_pkg::*;
(
    input  logic [INST_W-1:0] i_inst,
    output logic [31:0]       o_imm
);
    major_op_e opcode;
    logic      fmt_i;
    logic      fmt_s;
    logic      fmt_b;
    logic      fmt_u;
    logic      fmt_j;
    logic      sign;

    assign opcode = major_op_e'(i_inst[6:2]);
    assign sign   = i_inst[31];

    // format flags from the major opcode
    always_comb begin
        fmt_i = 1'b0;
        fmt_s = 1'b0;
        fmt_b = 1'b0;
        fmt_u = 1'b0;
        fmt_j = 1'b0;
        case (opcode)
            OP_IMM, OP_IMM_32, JALR, LOAD: fmt_i = 1'b1;
            STORE:                         fmt_s = 1'b1;
            BRANCH:                        fmt_b = 1'b1;
            LUI, AUIPC:                    fmt_u = 1'b1;
            JAL:                           fmt_j = 1'b1;
            // r format and unknown opcodes, sign-based bits only
            default: ;
        endcase
    end

    // bit 0 only exists in i and s
    assign o_imm[0]     = (fmt_s & i_inst[7]) | (fmt_i & i_inst[20]);
    // s/b take rd field, i/j take rs2 field
    assign o_imm[4:1]   = ({4{fmt_s | fmt_b}} & i_inst[11:8]) |
                          ({4{fmt_i | fmt_j}} & i_inst[24:21]);
    assign o_imm[10:5]  = fmt_u ? 6'd0 : i_inst[30:25];
    // bit 11 moves around per format
    assign o_imm[11]    = fmt_b ? i_inst[7] : (fmt_j ? i_inst[20] : (fmt_u ? 1'b0 : sign));
    assign o_imm[19:12] = (fmt_u | fmt_j) ? i_inst[19:12] : {8{sign}};
    assign o_imm[30:20] = fmt_u ? i_inst[30:20] : {11{sign}};
    assign o_imm[31]    = sign;

endmodule

//--- verilog/decode_pkg.sv
package decode_pkg;

    // fetch delivers fixed 32-bit instructions
    localparam int INST_W = 32;

    // major opcode, taken from inst[6:2]
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        OP_IMM    = 5'b00100,
        AUIPC     = 5'b00101,
        OP_IMM_32 = 5'b00110,
        STORE     = 5'b01000,
        OP        = 5'b01100,
        LUI       = 5'b01101,
        OP_32     = 5'b01110,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011
    } major_op_e;

    // backend pipeline select
    typedef enum logic [3:0] {
        PIPE_NONE   = 4'd0,
        PIPE_XARITH = 4'd1,
        PIPE_XLOGIC = 4'd2
    } pipe_e;

    // arithmetic unit operation
    typedef enum logic [1:0] {
        XARITH_ADD = 2'd0,
        XARITH_SLT = 2'd1
    } xarith_op_e;

    // logic unit operation
    typedef enum logic [2:0] {
        XLOGIC_AND = 3'd0,
        XLOGIC_OR  = 3'd1,
        XLOGIC_XOR = 3'd2,
        XLOGIC_SHF = 3'd3
    } xlogic_op_e;

    // arithmetic unit controls
    // cmp_mode and branch bits kept for issue, always zero here
    typedef struct packed {
        xarith_op_e op;
        logic       sub;
        logic       is_unsigned;
        logic       cmp_mode;
        logic       branch_equal;
        logic       branch_invert;
        logic       word;
    } xarith_ctrl_t;

    // logic unit controls
    typedef struct packed {
        xlogic_op_e op;
        logic       invert;
        logic [1:0] sll;
        logic       word;
    } xlogic_ctrl_t;

    // one decoded instruction as handed to issue
    typedef struct packed {
        logic         legal;
        logic [4:0]   rs1;
        logic [4:0]   rs2;
        logic [4:0]   rd;
        logic [31:0]  imm;
        pipe_e        pipe;
        logic         op2_sel;
        xarith_ctrl_t xarith;
        xlogic_ctrl_t xlogic;
    } decoded_t;

    // both lanes, lane0 in the low half
    typedef struct packed {
        decoded_t lane1;
        decoded_t lane0;
    } decoded_pair_t;

endpackage
